// File: dnc_output_consts.svh
// Width and depth macros of the output-vector MAC; include wherever the sizes are needed
`ifndef DNC_OUTPUT_CONSTS_SVH
`define DNC_OUTPUT_CONSTS_SVH

////////////////////////////////////////
// Data format, signed Q8.8
////////////////////////////////////////
// Weights, operands and outputs
`define DNC_DATA_W 16
// Fraction bits, dropped once at the drain
`define DNC_FRAC_W 8

////////////////////////////////////////
// Vector geometry
////////////////////////////////////////
`define DNC_Y_MAX 8
`define DNC_IDX_W 3
// Headroom for many full-width products
`define DNC_ACC_W 40

`endif

// File: dnc_output_pkg.sv
// Types exchanged between the output-vector MAC stages and with the outside; import where used
`default_nettype none
`include "dnc_output_consts.svh"

package dnc_output_pkg;

  ////////////////////////////////////////
  // Input term, one strobe per K*r or U*h term
  ////////////////////////////////////////
  typedef struct packed {
    logic [`DNC_IDX_W-1:0]         idx;
    logic signed [`DNC_DATA_W-1:0] weight;
    logic signed [`DNC_DATA_W-1:0] operand;
    logic                          last;
  } term_t;

  // Exact product, still carrying its index
  typedef struct packed {
    logic [`DNC_IDX_W-1:0]           idx;
    logic signed [2*`DNC_DATA_W-1:0] prod;
    logic                            last;
  } product_t;

  ////////////////////////////////////////
  // Output side
  ////////////////////////////////////////
  // One finished element of y
  typedef struct packed {
    logic [`DNC_IDX_W-1:0]         idx;
    logic signed [`DNC_DATA_W-1:0] value;
    logic                          sat;
  } y_elem_t;

  // Partial sum word of the bank
  typedef logic signed [`DNC_ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

// File: dnc_term_product.sv
// Product stage of the output-vector MAC; registers each term with its exact signed product
`timescale 1ns/100ps
`default_nettype none
`include "dnc_output_consts.svh"

module dnc_term_product
  import dnc_output_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  // Term strobe from the source
  input  logic     term_valid,
  input  term_t    term,
  // Product strobe toward the bank
  output logic     prod_valid,
  output product_t prod
);

  ////////////////////////////////////////
  // Multiply
  ////////////////////////////////////////

  // Full-width result, rounding deferred to the drain
  logic signed [2*`DNC_DATA_W-1:0] mult;

  // Same multiplier for K*r and U*h terms
  assign mult = $signed(term.weight) * $signed(term.operand);

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod_valid <= 1'b0;
      prod       <= '0;
    end else begin
      // One cycle of latency, strobe follows the term
      prod_valid <= term_valid;
      if (term_valid) begin
        // Index and last ride along with the product
        prod.idx  <= term.idx;
        prod.prod <= mult;
        prod.last <= term.last;
      end
    end
  end

endmodule

`default_nettype wire

// File: dnc_accum_bank.sv
// Accumulator bank of the output-vector MAC; one partial sum per y element, read by the drain
`timescale 1ns/100ps
`default_nettype none
`include "dnc_output_consts.svh"

module dnc_accum_bank
  import dnc_output_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  // Vector start with its length minus one
  input  logic                  start,
  input  logic [`DNC_IDX_W-1:0] size_y_in,
  // Products from the multiply stage
  input  logic                  prod_valid,
  input  product_t              prod,
  // Read port for the drain
  input  logic [`DNC_IDX_W-1:0] rd_idx,
  output acc_t                  rd_data,
  // Latched length and end-of-vector strobe
  output logic [`DNC_IDX_W-1:0] size_y,
  output logic                  done
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // One accumulator per output element
  acc_t acc_mem [`DNC_Y_MAX];

  // Product widened to accumulator width
  acc_t prod_ext;

  // Sign bit copied into the headroom
  assign prod_ext = {{(`DNC_ACC_W-2*`DNC_DATA_W){prod.prod[2*`DNC_DATA_W-1]}}, prod.prod};

  ////////////////////////////////////////
  // Accumulate
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < `DNC_Y_MAX; i++) begin
        acc_mem[i] <= '0;
      end
      size_y <= '0;
      done   <= 1'b0;
    end else begin
      // Done one cycle after the last product is summed
      done <= prod_valid & prod.last;

      if (start) begin
        // Fresh vector, stale sums of a longer one wiped
        for (int i = 0; i < `DNC_Y_MAX; i++) begin
          acc_mem[i] <= '0;
        end
        size_y <= size_y_in;
      end else if (prod_valid) begin
        // K*r and U*h terms land in the same entry
        acc_mem[prod.idx] <= acc_mem[prod.idx] + prod_ext;
      end
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Combinational, drain sees the entry in the same cycle
  assign rd_data = acc_mem[rd_idx];

endmodule

`default_nettype wire

// File: dnc_output_drain.sv
// Drain stage of the output-vector MAC; rounds, saturates and streams y, then pulses ready
`timescale 1ns/100ps
`default_nettype none
`include "dnc_output_consts.svh"

module dnc_output_drain
  import dnc_output_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  // From the bank
  input  logic                  done,
  input  logic [`DNC_IDX_W-1:0] size_y,
  output logic [`DNC_IDX_W-1:0] rd_idx,
  input  acc_t                  rd_data,
  // Output stream
  output logic                  y_valid,
  output y_elem_t               y,
  output logic                  ready
);

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  localparam logic st_idle  = 1'b0;
  localparam logic st_drain = 1'b1;

  // Half an LSB of the output format
  localparam acc_t round_half = acc_t'(1) <<< (`DNC_FRAC_W-1);

  // Signed data limits at rounded width
  localparam logic signed [`DNC_ACC_W:0] y_hi =
    {{(`DNC_ACC_W-`DNC_DATA_W+2){1'b0}}, {(`DNC_DATA_W-1){1'b1}}};
  localparam logic signed [`DNC_ACC_W:0] y_lo =
    {{(`DNC_ACC_W-`DNC_DATA_W+2){1'b1}}, {(`DNC_DATA_W-1){1'b0}}};

  logic                         state;
  logic [`DNC_IDX_W-1:0]        cnt;
  logic signed [`DNC_ACC_W:0]   rounded;

  ////////////////////////////////////////
  // FSM and index counter
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= st_idle;
      cnt   <= '0;
      ready <= 1'b0;
    end else begin
      // Pulse right after the final element
      ready <= (state == st_drain) && (cnt == size_y);
      case (state)
        st_idle: begin
          // A second done while busy is never seen here
          if (done) begin
            state <= st_drain;
            cnt   <= '0;
          end
        end
        default: begin
          if (cnt == size_y) begin
            state <= st_idle;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Round half-up, then saturate
  ////////////////////////////////////////

  assign rd_idx = cnt;

  // One extra bit so the half-LSB add cannot wrap
  assign rounded = ($signed({rd_data[`DNC_ACC_W-1], rd_data}) + round_half) >>> `DNC_FRAC_W;

  always_comb begin
    y.idx = cnt;
    y.sat = 1'b0;
    y.value = rounded[`DNC_DATA_W-1:0];
    if (rounded > y_hi) begin
      y.value = y_hi[`DNC_DATA_W-1:0];
      y.sat   = 1'b1;
    end else if (rounded < y_lo) begin
      y.value = y_lo[`DNC_DATA_W-1:0];
      y.sat   = 1'b1;
    end
  end

  // One element per drain cycle
  assign y_valid = (state == st_drain);

endmodule

`default_nettype wire

// File: dnc_output_vector.sv
// Top of the output-vector MAC, y = K*r + U*h from one interleaved term stream
`timescale 1ns/100ps
`default_nettype none
`include "dnc_output_consts.svh"

module dnc_output_vector
  import dnc_output_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  // Vector control
  input  logic                  START,
  input  logic [`DNC_IDX_W-1:0] size_y,
  // Term stream
  input  logic                  term_valid,
  input  term_t                 term,
  // Result stream
  output logic                  y_valid,
  output y_elem_t               y,
  output logic                  READY
);

  ////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////

  logic                  prod_valid;
  product_t              prod;
  logic [`DNC_IDX_W-1:0] rd_idx;
  acc_t                  rd_data;
  // Length as latched by the bank at START
  logic [`DNC_IDX_W-1:0] bank_size_y;
  logic                  done;

  // Multiply each term
  dnc_term_product u_term_product (
    .CLK        (CLK),
    .RST        (RST),
    .term_valid (term_valid),
    .term       (term),
    .prod_valid (prod_valid),
    .prod       (prod)
  );

  // Sum per output element
  dnc_accum_bank u_accum_bank (
    .CLK        (CLK),
    .RST        (RST),
    .start      (START),
    .size_y_in  (size_y),
    .prod_valid (prod_valid),
    .prod       (prod),
    .rd_idx     (rd_idx),
    .rd_data    (rd_data),
    .size_y     (bank_size_y),
    .done       (done)
  );

  // Stream the finished vector
  dnc_output_drain u_output_drain (
    .CLK     (CLK),
    .RST     (RST),
    .done    (done),
    .size_y  (bank_size_y),
    .rd_idx  (rd_idx),
    .rd_data (rd_data),
    .y_valid (y_valid),
    .y       (y),
    .ready   (READY)
  );

endmodule

`default_nettype wire

// File: tb_dnc_output_table.svh
// Directed vectors for the output-vector testbench; included inside the testbench module
`ifndef TB_DNC_OUTPUT_TABLE_SVH
`define TB_DNC_OUTPUT_TABLE_SVH

////////////////////////////////////////
// Vector shapes
////////////////////////////////////////
localparam int num_dir       = 5;
localparam int num_dir_terms = 16;
localparam int num_dir_exp   = 16;

// Per vector: size_y, then number of terms
localparam int dir_size  [num_dir] = '{2, 3, 4, 2, 0};
localparam int dir_nterm [num_dir] = '{3, 6, 5, 1, 1};

// Terms: idx, weight, operand, last
localparam term_t dir_terms [num_dir_terms] = '{
  // U*h only, half-up on element 2
  '{3'd0, 16'h0100, 16'h0280, 1'b0}, '{3'd1, 16'h0180, 16'hff00, 1'b0},
  '{3'd2, 16'h0001, 16'h0080, 1'b1},
  // K*r and U*h interleaved on shared indices
  '{3'd1, 16'h0200, 16'h0100, 1'b0}, '{3'd0, 16'h0040, 16'h0400, 1'b0},
  '{3'd1, 16'hff00, 16'h0080, 1'b0}, '{3'd3, 16'h0100, 16'hff80, 1'b0},
  '{3'd0, 16'h0100, 16'h0100, 1'b0}, '{3'd1, 16'h0010, 16'h0010, 1'b1},
  // Clamp both ways, then both limits reached exactly
  '{3'd0, 16'h7fff, 16'h7fff, 1'b0}, '{3'd1, 16'h8000, 16'h7fff, 1'b0},
  '{3'd2, 16'h7fff, 16'h0100, 1'b0}, '{3'd3, 16'h8000, 16'h0100, 1'b0},
  '{3'd4, 16'h0300, 16'h0200, 1'b1},
  // Short vectors right after the long one
  '{3'd0, 16'h0100, 16'h0100, 1'b1},
  '{3'd0, 16'hff00, 16'h0300, 1'b1}
};

// Expected: idx, value, sat
localparam y_elem_t dir_exp [num_dir_exp] = '{
  '{3'd0, 16'h0280, 1'b0}, '{3'd1, 16'hfe80, 1'b0}, '{3'd2, 16'h0001, 1'b0},
  '{3'd0, 16'h0200, 1'b0}, '{3'd1, 16'h0181, 1'b0}, '{3'd2, 16'h0000, 1'b0},
  '{3'd3, 16'hff80, 1'b0},
  '{3'd0, 16'h7fff, 1'b1}, '{3'd1, 16'h8000, 1'b1}, '{3'd2, 16'h7fff, 1'b0},
  '{3'd3, 16'h8000, 1'b0}, '{3'd4, 16'h0600, 1'b0},
  '{3'd0, 16'h0100, 1'b0}, '{3'd1, 16'h0000, 1'b0}, '{3'd2, 16'h0000, 1'b0},
  '{3'd0, 16'hfd00, 1'b0}
};

`endif

// File: tb_dnc_output_vector.sv
// Testbench for the output-vector MAC; runs the directed table, then LCG random vectors
`timescale 1ns/100ps
`default_nettype none
`include "dnc_output_consts.svh"

module tb_dnc_output_vector
  import dnc_output_pkg::*;
();

  // Random vector count and the most terms in one random vector
  localparam int num_rand  = 40;
  localparam int max_terms = 12;
  // Q8.8 output limits and half an output LSB
  localparam longint y_max    = (longint'(1) <<< (`DNC_DATA_W-1)) - longint'(1);
  localparam longint y_min    = -(longint'(1) <<< (`DNC_DATA_W-1));
  localparam longint half_lsb = longint'(1) <<< (`DNC_FRAC_W-1);

  `include "tb_dnc_output_table.svh"

  logic                  CLK;
  logic                  RST;
  logic                  START;
  logic [`DNC_IDX_W-1:0] size_y;
  logic                  term_valid;
  term_t                 term;
  logic                  y_valid;
  y_elem_t               y;
  logic                  READY;

  // Terms to send and elements to expect for the current vector
  term_t       term_q[$];
  y_elem_t     exp_q[$];
  logic [31:0] rng_state;
  int          cycle_count;
  int          cycle_limit;

  dnc_output_vector u_dnc_output_vector (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .size_y     (size_y),
    .term_valid (term_valid),
    .term       (term),
    .y_valid    (y_valid),
    .y          (y),
    .READY      (READY)
  );

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////
  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      abort_run("Timeout, the DUT never finished the vector");
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_y_elem(input y_elem_t got, input y_elem_t exp);
    if (got !== exp) begin
      $display("FAIL %0t y: got idx=%0d value=%h sat=%b, expected idx=%0d value=%h sat=%b",
               $time, got.idx, got.value, got.sat, exp.idx, exp.value, exp.sat);
      abort_run("Output element mismatch");
    end
  endtask

  task automatic check_ready(input int latency, input logic [`DNC_IDX_W-1:0] size);
    if (latency != int'(size) + 4) begin
      $display("FAIL %0t READY latency: got %0d, expected %0d",
               $time, latency, int'(size) + 4);
      abort_run("READY came at the wrong cycle");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %0t %s: got %b, expected %b", $time, name, got, exp);
      abort_run("Control strobe mismatch");
    end
  endtask

  ////////////////////////////////////////
  // Random vectors and reference model
  ////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper half of the LCG state holds the better bits
  task automatic draw_bits(output logic [15:0] bits);
    rng_state = lcg_next(rng_state);
    bits = rng_state[31:16];
  endtask

  // Round half-up to Q8.8, then clamp
  function automatic y_elem_t model_elem(input int j, input longint sum);
    y_elem_t e;
    longint  r;
    r = (sum + half_lsb) >>> `DNC_FRAC_W;
    e.idx   = j[`DNC_IDX_W-1:0];
    e.sat   = 1'b0;
    e.value = r[`DNC_DATA_W-1:0];
    if (r > y_max) begin
      e.value = y_max[`DNC_DATA_W-1:0];
      e.sat   = 1'b1;
    end else if (r < y_min) begin
      e.value = y_min[`DNC_DATA_W-1:0];
      e.sat   = 1'b1;
    end
    return e;
  endfunction

  task automatic build_random_vector(output logic [`DNC_IDX_W-1:0] size);
    longint      sums [`DNC_Y_MAX];
    logic [15:0] bits;
    term_t       t;
    int          n_terms;
    int          idx_val;
    term_q.delete();
    exp_q.delete();
    foreach (sums[j]) sums[j] = '0;
    draw_bits(bits);
    size = bits[`DNC_IDX_W-1:0];
    draw_bits(bits);
    n_terms = 1 + int'(bits) % max_terms;
    for (int i = 0; i < n_terms; i++) begin
      draw_bits(bits);
      idx_val = int'(bits) % (int'(size) + 1);
      t.idx = idx_val[`DNC_IDX_W-1:0];
      // Narrow operands keep clamping rare
      draw_bits(bits);
      t.weight = {{6{bits[9]}}, bits[9:0]};
      draw_bits(bits);
      t.operand = {{4{bits[11]}}, bits[11:0]};
      t.last = (i == n_terms - 1);
      term_q.push_back(t);
      sums[idx_val] = sums[idx_val] + longint'($signed(t.weight)) * longint'($signed(t.operand));
    end
    for (int j = 0; j <= int'(size); j++) begin
      exp_q.push_back(model_elem(j, sums[j]));
    end
  endtask

  ////////////////////////////////////////
  // One vector from START through READY
  ////////////////////////////////////////
  task automatic run_vector(input logic [`DNC_IDX_W-1:0] size);
    int lat;
    int n_seen;
    bit got_ready;
    @(negedge CLK);
    // No strobe between vectors since READY lasts one cycle
    check_flag("y_valid", y_valid, 1'b0);
    check_flag("READY", READY, 1'b0);
    START  = 1'b1;
    size_y = size;
    @(negedge CLK);
    START = 1'b0;
    // One term per cycle from the cycle after START
    for (int i = 0; i < term_q.size(); i++) begin
      if (i > 0) @(negedge CLK);
      check_flag("y_valid", y_valid, 1'b0);
      check_flag("READY", READY, 1'b0);
      term_valid = 1'b1;
      term       = term_q[i];
    end
    lat       = 0;
    n_seen    = 0;
    got_ready = 1'b0;
    while (!got_ready) begin
      @(negedge CLK);
      lat++;
      term_valid = 1'b0;
      term       = '0;
      if (y_valid) begin
        if (n_seen >= exp_q.size()) begin
          abort_run("More output elements than size_y+1");
        end else begin
          check_y_elem(y, exp_q[n_seen]);
          n_seen++;
        end
      end
      if (READY) begin
        check_ready(lat, size);
        if (n_seen != exp_q.size()) begin
          abort_run("READY came before all output elements");
        end
        got_ready = 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    logic [`DNC_IDX_W-1:0] size;
    int t_base;
    int e_base;
    CLK         = 1'b0;
    RST         = 1'b1;
    START       = 1'b0;
    size_y      = '0;
    term_valid  = 1'b0;
    term        = '0;
    rng_state   = 32'hb0a9;
    cycle_count = 0;
    // Reset, idle window, random worst case and some slack
    cycle_limit = 2 + 8 + num_rand * (max_terms + `DNC_Y_MAX + 6) + 50;
    for (int v = 0; v < num_dir; v++) begin
      cycle_limit += dir_nterm[v] + dir_size[v] + 6;
    end

    repeat (2) @(negedge CLK);
    RST = 1'b0;

    // Quiet outputs before the first START
    repeat (6) begin
      @(negedge CLK);
      check_flag("y_valid", y_valid, 1'b0);
      check_flag("READY", READY, 1'b0);
    end

    // Directed table
    t_base = 0;
    e_base = 0;
    for (int v = 0; v < num_dir; v++) begin
      term_q.delete();
      exp_q.delete();
      for (int i = 0; i < dir_nterm[v]; i++) begin
        term_q.push_back(dir_terms[t_base + i]);
      end
      for (int i = 0; i <= dir_size[v]; i++) begin
        exp_q.push_back(dir_exp[e_base + i]);
      end
      t_base += dir_nterm[v];
      e_base += dir_size[v] + 1;
      size = dir_size[v][`DNC_IDX_W-1:0];
      run_vector(size);
    end

    // Random vectors back to back
    for (int r = 0; r < num_rand; r++) begin
      build_random_vector(size);
      run_vector(size);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
dnc_output_pkg.sv
dnc_term_product.sv
dnc_accum_bank.sv
dnc_output_drain.sv
dnc_output_vector.sv
tb_dnc_output_vector.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_dnc_output_vector
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vtb_dnc_output_vector
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
